// File: all.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/bank_decode.sv
hdl/sram_sequencer.sv
hdl/read_steer.sv
hdl/mem_subsystem.sv
test/sram_model.sv
test/mem_subsystem_asserts.sv
test/mem_subsystem_tb.sv

// File: hdl/bank_decode.sv
`timescale 1ns/1ps

// splits an interleaved word address into bank parity and chip address
//
// even words live in the base chip, odd words in the ext chip, so the
// chip address is the bus address without its lowest bit. next_chip_addr
// serves the case where the pair starts on an odd word: the second word
// then sits in the base chip one row further on
module bank_decode
    import mem_pkg::*;
#(
    parameter type payload_t = fetch_pl_t
) (
    input  bus_addr_t  addr,
    input  payload_t   payload_in,
    output logic       even,
    output chip_addr_t chip_addr,
    output chip_addr_t next_chip_addr,
    output payload_t   payload_out
);

    localparam int BUS_AW = $bits(bus_addr_t);

    chip_addr_t half_addr;

    assign half_addr = addr[BUS_AW-1:1]; // drop the bank bit

    assign even = ~addr[0];

    assign chip_addr = half_addr;

    // wraps at the top of the chip, same as the bus address would
    assign next_chip_addr = half_addr + chip_addr_t'(1);

    // request fields travel alongside the decoded address
    assign payload_out = payload_in;

endmodule

// File: hdl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// word width on both buses and on each chip
`define WORD_W 32

// address width of one chip, in words
`define CHIP_AW 20

// byte lanes per word
`define BYTE_N 4

// bound for any polling loop, in clk cycles
`define WAIT_LIMIT 64

`endif

// File: hdl/mem_pkg.sv
package mem_pkg;

`include "mem_params.svh"

typedef logic [`WORD_W-1:0] word_t;

// bus word address, one bit wider than a chip address for bank select
typedef logic [`CHIP_AW:0] bus_addr_t;

typedef logic [`CHIP_AW-1:0] chip_addr_t;

typedef logic [`BYTE_N-1:0] mask_t; // 1 = byte enabled

typedef struct packed {
    logic  write;
    logic  read;
    word_t wdata;
    mask_t mask;
} data_pl_t;

// fetches carry no request data
typedef struct packed {
    logic rsvd;
} fetch_pl_t;

endpackage

// File: hdl/mem_subsystem.sv
`timescale 1ns/1ps

// two interleaved SRAM chips behind an instruction port and a data port
module mem_subsystem
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  bus_addr_t  inst_addr,
    output word_t      inst_data,
    output word_t      inst_data_2,
    output logic       inst_valid,

    input  bus_addr_t  data_addr,
    input  logic       data_read,
    input  logic       data_write,
    input  word_t      data_wdata,
    input  mask_t      data_mask,
    output word_t      data_rdata,
    output logic       stall,

    output logic       base_ce_n,
    output logic       base_oe_n,
    output logic       base_we_n,
    output mask_t      base_be_n,
    output chip_addr_t base_addr,
    output word_t      base_data_out,
    output logic       base_data_oe,
    input  word_t      base_data_in,

    output logic       ext_ce_n,
    output logic       ext_oe_n,
    output logic       ext_we_n,
    output mask_t      ext_be_n,
    output chip_addr_t ext_addr,
    output word_t      ext_data_out,
    output logic       ext_data_oe,
    input  word_t      ext_data_in
);

    fetch_pl_t  fetch_req;
    data_pl_t   data_req;
    data_pl_t   data_pl;
    logic       inst_even;
    chip_addr_t inst_chip_addr;
    chip_addr_t inst_next_addr;
    logic       data_even;
    chip_addr_t data_chip_addr;
    logic       pending;
    logic       phase;

    assign fetch_req = '0;
    assign data_req  = '{write: data_write, read: data_read, wdata: data_wdata, mask: data_mask};

    bank_decode #(
        .payload_t(fetch_pl_t)
    ) u_inst_decode (
        .addr           (inst_addr),
        .payload_in     (fetch_req),
        .even           (inst_even),
        .chip_addr      (inst_chip_addr),
        .next_chip_addr (inst_next_addr),
        .payload_out    ()
    );

    bank_decode #(
        .payload_t(data_pl_t)
    ) u_data_decode (
        .addr           (data_addr),
        .payload_in     (data_req),
        .even           (data_even),
        .chip_addr      (data_chip_addr),
        .next_chip_addr (),
        .payload_out    (data_pl)
    );

    sram_sequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .inst_even      (inst_even),
        .inst_chip_addr (inst_chip_addr),
        .inst_next_addr (inst_next_addr),
        .data_even      (data_even),
        .data_chip_addr (data_chip_addr),
        .data_pl        (data_pl),
        .pending        (pending),
        .phase          (phase),
        .base_ce_n      (base_ce_n),
        .base_oe_n      (base_oe_n),
        .base_we_n      (base_we_n),
        .base_be_n      (base_be_n),
        .base_addr      (base_addr),
        .base_data_out  (base_data_out),
        .base_data_oe   (base_data_oe),
        .ext_ce_n       (ext_ce_n),
        .ext_oe_n       (ext_oe_n),
        .ext_we_n       (ext_we_n),
        .ext_be_n       (ext_be_n),
        .ext_addr       (ext_addr),
        .ext_data_out   (ext_data_out),
        .ext_data_oe    (ext_data_oe)
    );

    read_steer u_steer (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .pending     (pending),
        .data_even   (data_even),
        .base_rdata  (base_data_in),
        .ext_rdata   (ext_data_in),
        .inst_even   (inst_even),
        .inst_data   (inst_data),
        .inst_data_2 (inst_data_2),
        .inst_valid  (inst_valid),
        .data_rdata  (data_rdata),
        .stall       (stall)
    );

endmodule

// File: hdl/read_steer.sv
`timescale 1ns/1ps

// returns read words to the two buses
//
// the instruction pair is valid in the clk after a fetch edge, while both
// chips still drive the fetched rows. a data read is captured at the fetch
// edge that ends the pending access
module read_steer
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  phase,
    input  logic  pending,
    input  logic  data_even,
    input  word_t base_rdata,
    input  word_t ext_rdata,
    input  logic  inst_even,
    output word_t inst_data,
    output word_t inst_data_2,
    output logic  inst_valid,
    output word_t data_rdata,
    output logic  stall
);

    logic fetch_even; // parity of the pair being returned
    logic sel_even;   // bank of the data access in flight

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_even <= 1'b1;
            sel_even   <= 1'b1;
            data_rdata <= '0;
        end else if (!phase) begin
            fetch_even <= inst_even;
            if (pending) begin
                data_rdata <= sel_even ? base_rdata : ext_rdata;
            end else begin
                sel_even <= data_even; // holds for the request taken now
            end
        end
    end

    // addressed word first, its successor second
    assign inst_data   = fetch_even ? base_rdata : ext_rdata;
    assign inst_data_2 = fetch_even ? ext_rdata : base_rdata;

    assign inst_valid = phase;

    assign stall = pending;

endmodule

// File: hdl/sram_sequencer.sv
`timescale 1ns/1ps

// drives the pins of both SRAM chips, alternating fetch and data phases
//
// phase is low while the next edge is a fetch edge. at a fetch edge both
// chips are set up to read the instruction pair, and a new data request
// is taken if none is pending. at the following data edge the pending
// access, if any, goes to the chip picked by its parity; its strobes are
// active for one clk and end at the next fetch edge
module sram_sequencer
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       inst_even,
    input  chip_addr_t inst_chip_addr,
    input  chip_addr_t inst_next_addr,

    input  logic       data_even,
    input  chip_addr_t data_chip_addr,
    input  data_pl_t   data_pl,

    output logic       pending,
    output logic       phase,

    output logic       base_ce_n,
    output logic       base_oe_n,
    output logic       base_we_n,
    output mask_t      base_be_n,
    output chip_addr_t base_addr,
    output word_t      base_data_out,
    output logic       base_data_oe,

    output logic       ext_ce_n,
    output logic       ext_oe_n,
    output logic       ext_we_n,
    output mask_t      ext_be_n,
    output chip_addr_t ext_addr,
    output word_t      ext_data_out,
    output logic       ext_data_oe
);

    logic       fetch_edge;
    logic       req_even;
    chip_addr_t req_addr;
    data_pl_t   req_pl;
    mask_t      req_be_n;

    assign fetch_edge = ~phase;

    // reads enable every lane, writes only the masked ones
    assign req_be_n = req_pl.write ? ~req_pl.mask : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= 1'b0; // first edge after reset is a fetch edge
            pending <= 1'b0;
        end else begin
            phase <= ~phase;
            if (fetch_edge) begin
                // a request seen as pending ends here, and the same
                // request is not taken again on this edge
                if (pending) begin
                    pending <= 1'b0;
                end else begin
                    pending <= data_pl.read | data_pl.write;
                end
            end
        end
    end

    // request is latched when it is accepted
    always_ff @(posedge clk) begin
        if (fetch_edge && !pending) begin
            req_even <= data_even;
            req_addr <= data_chip_addr;
            req_pl   <= data_pl;
        end
    end

    // chip strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_ce_n    <= 1'b1;
            base_oe_n    <= 1'b1;
            base_we_n    <= 1'b1;
            base_data_oe <= 1'b0;
            ext_ce_n     <= 1'b1;
            ext_oe_n     <= 1'b1;
            ext_we_n     <= 1'b1;
            ext_data_oe  <= 1'b0;
        end else if (fetch_edge) begin
            // instruction pair, both chips read
            base_ce_n    <= 1'b0;
            base_oe_n    <= 1'b0;
            base_we_n    <= 1'b1;
            base_data_oe <= 1'b0;
            ext_ce_n     <= 1'b0;
            ext_oe_n     <= 1'b0;
            ext_we_n     <= 1'b1;
            ext_data_oe  <= 1'b0;
        end else if (pending) begin
            base_ce_n    <= ~req_even;
            base_oe_n    <= ~(req_even & req_pl.read);
            base_we_n    <= ~(req_even & req_pl.write);
            base_data_oe <= req_even & req_pl.write;
            ext_ce_n     <= req_even;
            ext_oe_n     <= ~(~req_even & req_pl.read);
            ext_we_n     <= ~(~req_even & req_pl.write);
            ext_data_oe  <= ~req_even & req_pl.write;
        end else begin
            // no data access, both chips deselected
            base_ce_n    <= 1'b1;
            base_oe_n    <= 1'b1;
            base_we_n    <= 1'b1;
            base_data_oe <= 1'b0;
            ext_ce_n     <= 1'b1;
            ext_oe_n     <= 1'b1;
            ext_we_n     <= 1'b1;
            ext_data_oe  <= 1'b0;
        end
    end

    // address, lane and write data pins
    always_ff @(posedge clk) begin
        if (fetch_edge) begin
            // an odd pair wraps into the next base row
            base_addr <= inst_even ? inst_chip_addr : inst_next_addr;
            ext_addr  <= inst_chip_addr;
            base_be_n <= '0;
            ext_be_n  <= '0;
        end else begin
            base_addr     <= req_addr;
            ext_addr      <= req_addr;
            base_be_n     <= req_be_n;
            ext_be_n      <= req_be_n;
            base_data_out <= req_pl.wdata;
            ext_data_out  <= req_pl.wdata;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module mem_subsystem_tb -o sim_mem \
    && ./obj_dir/sim_mem \
    || exit 1

// File: test/mem_subsystem_asserts.sv
`timescale 1ns/1ps

// pin-level rules of the memory subsystem
module mem_subsystem_asserts (
    input logic clk,
    input logic rst,
    input logic base_we_n,
    input logic ext_we_n,
    input logic phase,
    input logic stall
);

    logic [1:0] stall_run; // consecutive edges with stall high, saturating

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stall_run <= '0;
        end else if (stall) begin
            stall_run <= (stall_run == 2'd3) ? 2'd3 : stall_run + 2'd1;
        end else begin
            stall_run <= '0;
        end
    end

    one_writer: assert property (@(posedge clk) disable iff (rst) base_we_n || ext_we_n)
        else $error("both chips write enabled together");

    // strobes are set at the data edge, so phase reads low while they are active
    write_in_data_phase: assert property (@(posedge clk) disable iff (rst)
        (!base_we_n || !ext_we_n) |-> !phase)
        else $error("write strobe outside the data phase");

    stall_bounded: assert property (@(posedge clk) disable iff (rst) stall_run <= 2'd2)
        else $error("stall high for more than 2 clk");

endmodule

bind mem_subsystem mem_subsystem_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .base_we_n (base_we_n),
    .ext_we_n  (ext_we_n),
    .phase     (phase),
    .stall     (stall)
);

// File: test/mem_subsystem_tb.sv
`timescale 1ns/1ps

`include "mem_params.svh"

module mem_subsystem_tb
    import mem_pkg::*;
;

    typedef struct packed {
        logic      wr; // 1 = write, 0 = read
        bus_addr_t addr;
        word_t     data;
        mask_t     mask;
    } op_t;

    localparam int N_OPS = 12;
    localparam int N_RAND = 40;

    op_t ops [N_OPS] = '{
        '{1'b1, 21'd4,       32'h1111_1111, 4'hF},
        '{1'b1, 21'd5,       32'h2222_2222, 4'hF},
        '{1'b0, 21'd4,       32'h0,         4'hF},
        '{1'b0, 21'd5,       32'h0,         4'hF},
        '{1'b1, 21'd6,       32'hA5A5_A5A5, 4'hF},
        '{1'b1, 21'd6,       32'h00CC_0000, 4'b0100},
        '{1'b0, 21'd6,       32'h0,         4'hF},
        '{1'b1, 21'd7,       32'hDEAD_BEEF, 4'b1001},
        '{1'b0, 21'd7,       32'h0,         4'hF},
        '{1'b0, 21'd9,       32'h0,         4'hF}, // never written
        '{1'b1, 21'h1F_FFFF, 32'h1357_2468, 4'hF},
        '{1'b0, 21'h1F_FFFF, 32'h0,         4'hF}
    };

    logic       clk;
    logic       rst;
    bus_addr_t  inst_addr;
    word_t      inst_data;
    word_t      inst_data_2;
    logic       inst_valid;
    bus_addr_t  data_addr;
    logic       data_read;
    logic       data_write;
    word_t      data_wdata;
    mask_t      data_mask;
    word_t      data_rdata;
    logic       stall;

    logic       base_ce_n, base_oe_n, base_we_n, base_data_oe;
    mask_t      base_be_n;
    chip_addr_t base_addr;
    word_t      base_data_out, base_data_in;
    logic       ext_ce_n, ext_oe_n, ext_we_n, ext_data_oe;
    mask_t      ext_be_n;
    chip_addr_t ext_addr;
    word_t      ext_data_out, ext_data_in;

    word_t       ref_mem [bus_addr_t]; // only words written so far
    logic [31:0] rng = 32'd59132;
    bus_addr_t   fetched_addr;
    logic        have_fetch = 1'b0;
    logic        pair_due = 1'b0; // pair expected at this falling edge
    int          fetch_cnt = 0;

    mem_subsystem dut (.*);

    sram_model #(.BANK(1'b0)) u_base_sram (
        .ce_n(base_ce_n), .oe_n(base_oe_n), .we_n(base_we_n), .be_n(base_be_n),
        .addr(base_addr), .wdata(base_data_out), .wdata_oe(base_data_oe),
        .rdata(base_data_in)
    );

    sram_model #(.BANK(1'b1)) u_ext_sram (
        .ce_n(ext_ce_n), .oe_n(ext_oe_n), .we_n(ext_we_n), .be_n(ext_be_n),
        .addr(ext_addr), .wdata(ext_data_out), .wdata_oe(ext_data_oe),
        .rdata(ext_data_in)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // power-up contents are a hash of the whole bus address
    function automatic word_t fill_word(input bus_addr_t a);
        return 32'hC3A5_0F00 ^ ({11'd0, a} * 32'h9E37_79B1);
    endfunction

    function automatic word_t ref_word(input bus_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    task automatic fail_now();
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic timeout(input string what);
        $display("Timed out after %0d clk waiting for %s", `WAIT_LIMIT, what);
        fail_now();
    endtask

    // checks the pair returned in a data phase and picks the next fetch address
    task automatic fetch_bookkeep();
        check_flag(inst_valid, pair_due, "inst_valid");
        if (pair_due) begin
            if (have_fetch) begin
                check_word(inst_data, ref_word(fetched_addr), "inst_data");
                check_word(inst_data_2, ref_word(fetched_addr + bus_addr_t'(1)), "inst_data_2");
            end
        end else begin
            rng = xorshift(rng);
            fetch_cnt++;
            // now and then the top word, whose pair wraps to word 0
            inst_addr = (fetch_cnt % 16 == 0) ? '1 : bus_addr_t'(rng[13:8]);
            fetched_addr = inst_addr;
            have_fetch = 1'b1;
        end
        pair_due = ~pair_due; // fetch and data phases alternate every clk
    endtask

    task automatic run_access(input op_t op);
        int    waited;
        int    held;
        word_t exp;
        exp = ref_word(op.addr);
        if (op.wr) begin
            for (int i = 0; i < `BYTE_N; i++) begin
                if (op.mask[i]) exp[8*i +: 8] = op.data[8*i +: 8];
            end
        end
        data_addr  = op.addr;
        data_write = op.wr;
        data_read  = !op.wr;
        data_wdata = op.data;
        data_mask  = op.mask;

        waited = 0;
        while (!stall) begin
            @(negedge clk);
            fetch_bookkeep();
            waited++;
            if (waited > `WAIT_LIMIT) timeout("stall to rise");
        end

        held = 1;
        forever begin
            @(negedge clk);
            if (!stall) break;
            held++;
            fetch_bookkeep();
            if (held > `WAIT_LIMIT) timeout("stall to fall");
        end

        check_flag(held == 2, 1'b1, "stall lasted 2 clk");
        if (op.wr) ref_mem[op.addr] = exp;
        else check_word(data_rdata, exp, "data_rdata");
        data_read  = 1'b0;
        data_write = 1'b0;
        fetch_bookkeep(); // sees the write that just landed
    endtask

    initial begin
        op_t op;
        rst        = 1'b1;
        inst_addr  = '0;
        data_addr  = '0;
        data_read  = 1'b0;
        data_write = 1'b0;
        data_wdata = '0;
        data_mask  = '0;

        repeat (3) @(negedge clk);
        check_flag(stall, 1'b0, "stall in reset");
        check_flag(inst_valid, 1'b0, "inst_valid in reset");
        check_word(data_rdata, '0, "data_rdata in reset");
        check_flag(base_ce_n & base_oe_n & base_we_n, 1'b1, "base strobes in reset");
        check_flag(ext_ce_n & ext_oe_n & ext_we_n, 1'b1, "ext strobes in reset");
        check_flag(base_data_oe | ext_data_oe, 1'b0, "data_oe in reset");
        rst = 1'b0;

        // fetches alone first
        for (int i = 0; i < 12; i++) begin
            if (i > 0) @(negedge clk);
            fetch_bookkeep();
        end

        for (int i = 0; i < N_OPS; i++) run_access(ops[i]);

        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift(rng);
            op.wr   = rng[0];
            op.addr = bus_addr_t'(rng[13:8]);
            op.mask = rng[1] ? 4'hF : rng[7:4];
            rng = xorshift(rng);
            op.data = rng;
            run_access(op);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: test/sram_model.sv
`timescale 1ns/1ps

`include "mem_params.svh"

// asynchronous word-wide SRAM with active-low byte enables
//
// reads are combinational while ce_n and oe_n are low. a write is taken
// at the rising edge of we_n, with the address and data that were on the
// pins shortly after we_n fell
module sram_model
    import mem_pkg::*;
#(
    parameter logic BANK = 1'b0 // 0 = even words, 1 = odd words
) (
    input  logic       ce_n,
    input  logic       oe_n,
    input  logic       we_n,
    input  mask_t      be_n,
    input  chip_addr_t addr,
    input  word_t      wdata,
    input  logic       wdata_oe,
    output word_t      rdata
);

    word_t      mem [0:(1 << `CHIP_AW)-1];
    chip_addr_t w_addr;
    word_t      w_data;
    mask_t      w_be_n;
    logic       w_en = 1'b0;

    // contents start as a hash of the bus address of each word
    initial begin
        for (int r = 0; r < (1 << `CHIP_AW); r++) begin
            mem[r] = 32'hC3A5_0F00 ^ ({11'd0, chip_addr_t'(r), BANK} * 32'h9E37_79B1);
        end
    end

    assign rdata = (!ce_n && !oe_n) ? mem[addr] : '0;

    always @(negedge we_n) begin
        #1; // pins settle after the strobe
        w_addr = addr;
        w_data = wdata;
        w_be_n = be_n;
        w_en   = !ce_n && wdata_oe;
    end

    always @(posedge we_n) begin
        if (w_en) begin
            for (int i = 0; i < `BYTE_N; i++) begin
                if (!w_be_n[i]) mem[w_addr][8*i +: 8] = w_data[8*i +: 8];
            end
        end
    end

endmodule
